// ==== all.f ====
src/vic_regs_pkg.sv
src/vic_video_pkg.sv
src/vic_reg_file.sv
src/vic_raster_timer.sv
src/vic_fetch_stage.sv
src/vic_pixel_stage.sv
src/vic_top.sv
tests/vic_props.sv
tests/vic_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module vic_tb \
  -o vic_sim && ./obj_dir/vic_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

// ==== src/vic_fetch_stage.sv ====
// ========================================
// Fetch stage for one line of character cells
// Reads matrix and glyph words from video memory and hands one item
// per cell to the pixel stage, spending a credit for every item sent
// ========================================
`timescale 1ns/1ps

module vic_fetch_stage (
  input  logic                       clk,
  input  logic                       rst,
  input  vic_regs_pkg::ctrl_t        ctrl,
  input  vic_regs_pkg::mem_ptr_t     mem_ptr,
  input  logic                       line_start,
  input  logic [4:0]                 vcount,
  output logic [13:0]                mem_adr,
  output logic                       mem_rd,
  input  logic [11:0]                mem_dat,
  output vic_video_pkg::fetch_item_t item,
  output logic                       item_valid,
  input  logic                       credit
);
  import vic_video_pkg::*;

  // Matrix read, its data cycle, glyph read and its data cycle
  typedef enum logic [2:0] {
    st_idle,
    st_mat,
    st_mat_w,
    st_gly,
    st_gly_w
  } state_t;

  state_t              state;
  logic [col_w-1:0]    col;
  logic [4:0]          line_y;
  logic [credit_w-1:0] credits;
  matrix_word_u        mat_in;
  matrix_word_u        mat_q;
  logic [13:0]         mat_adr;
  logic [13:0]         glyph_adr;
  logic                wait_credit;
  logic                send;

  // Read data arrives one clock after the read strobe
  assign mat_in = mem_dat;

  // ========================================
  // Address generation
  // ========================================

  // Matrix cell for this row and column, row being line_y / 8
  assign mat_adr = {mem_ptr.vm_base, 10'd0} + 14'(line_y[4:3] * cols + col);

  // Glyph line: base * 2048 + code * 8 + line within the cell
  assign glyph_adr = {mem_ptr.cb_base, mat_q.text.char_code, line_y[2:0]};

  // Without a credit the stage parks in st_mat with the address held
  assign wait_credit = (state == st_mat) && (credits == '0);

  assign mem_rd  = ((state == st_mat) && !wait_credit) || (state == st_gly);
  assign mem_adr = (state == st_gly) ? glyph_adr : mat_adr;

  // Bitmap cells finish on the matrix data, text cells on the glyph data
  assign send = ((state == st_mat_w) && ctrl.bmm) || (state == st_gly_w);

  // ========================================
  // Credit counter
  // ========================================

  // A returned credit and a spent one in the same clock cancel out
  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= credit_w'(fifo_depth);
    end else if (send && !credit) begin
      credits <= credits - 1'b1;
    end else if (credit && !send) begin
      credits <= credits + 1'b1;
    end
  end

  // ========================================
  // Sequencer
  // ========================================

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      col        <= '0;
      line_y     <= '0;
      item_valid <= 1'b0;
    end else begin
      item_valid <= send;
      case (state)
        st_idle: begin
          // The line is latched so a vcount change cannot split a row
          if (line_start && ctrl.den) begin
            line_y <= vcount;
            col    <= '0;
            state  <= st_mat;
          end
        end
        st_mat: begin
          if (!wait_credit) begin
            state <= st_mat_w;
          end
        end
        st_mat_w: state <= st_gly;
        st_gly:   state <= st_gly_w;
        default:  state <= st_idle;
      endcase
      // Sending a cell moves on to the next column or ends the line
      if (send) begin
        col   <= col + 1'b1;
        state <= (col == col_w'(cols - 1)) ? st_idle : st_mat;
      end
    end
  end

  // ========================================
  // Item payload
  // ========================================

  always_ff @(posedge clk) begin
    if (state == st_mat_w) begin
      mat_q <= mat_in;
    end
    if (send) begin
      item.x <= 6'({col, 3'b000});
      item.y <= line_y;
      // Glyph line and bitmap bits both sit in the low byte of the read word
      item.bits <= mem_dat[7:0];
      if (state == st_gly_w) begin
        // Colour of the matrix word read before the glyph
        item.colour <= mat_q.text.colour;
      end else begin
        item.colour <= mat_in.bitmap.colour;
      end
    end
  end

endmodule

// ==== src/vic_pixel_stage.sv ====
// ========================================
// Pixel stage with its item buffer and shifter
// Buffers items from the fetch stage, returns a credit per pop and
// shifts each item out as eight pixels, or draws border when blanked
// ========================================
`timescale 1ns/1ps

module vic_pixel_stage (
  input  logic                       clk,
  input  logic                       rst,
  input  vic_video_pkg::fetch_item_t item,
  input  logic                       item_valid,
  output logic                       credit,
  input  logic [3:0]                 border,
  input  vic_regs_pkg::ctrl_t        ctrl,
  input  logic [5:0]                 hcount,
  input  logic [4:0]                 vcount,
  output vic_video_pkg::pixel_t      pix
);
  import vic_video_pkg::*;

  fetch_item_t         fifo_mem [fifo_depth];
  logic [ptr_w-1:0]    wr_ptr;
  logic [ptr_w-1:0]    rd_ptr;
  logic [credit_w-1:0] count;
  logic                pop;
  // Item being shifted out, its bits move towards the MSB
  fetch_item_t         sh;
  logic [2:0]          sh_idx;
  logic [3:0]          sh_left;
  logic                visible;

  // Next item loads while the last pixel of the current one goes out
  assign pop = (count != '0) && (sh_left <= 4'd1);

  // Beam inside the active picture area
  assign visible = (hcount < 6'(h_visible)) && (vcount < 5'(v_visible));

  // ========================================
  // Item buffer
  // ========================================

  // Credits bound the fill level, so there is no full check here
  always_ff @(posedge clk) begin
    if (item_valid) begin
      fifo_mem[wr_ptr] <= item;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (item_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({item_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ========================================
  // Shifter
  // ========================================

  always_ff @(posedge clk) begin
    if (rst) begin
      sh_left <= '0;
      sh_idx  <= '0;
    end else if (pop) begin
      sh_left <= 4'd8;
      sh_idx  <= '0;
    end else if (sh_left != '0) begin
      sh_left <= sh_left - 4'd1;
      sh_idx  <= sh_idx + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      sh <= fifo_mem[rd_ptr];
    end else if (sh_left != '0) begin
      sh.bits <= {sh.bits[6:0], 1'b0};
    end
  end

  // ========================================
  // Pixel output and credit return
  // ========================================

  always_ff @(posedge clk) begin
    if (rst) begin
      pix    <= '0;
      credit <= 1'b0;
    end else begin
      credit <= pop;
      if (ctrl.den) begin
        // A set bit takes the cell colour, a clear bit is colour 0
        pix.valid  <= (sh_left != '0);
        pix.x      <= sh.x + 6'(sh_idx);
        pix.y      <= sh.y;
        pix.colour <= sh.bits[7] ? sh.colour : 4'd0;
      end else begin
        // Display off: the whole visible area shows the border colour
        pix.valid  <= visible;
        pix.x      <= hcount;
        pix.y      <= vcount;
        pix.colour <= border;
      end
    end
  end

endmodule

// ==== src/vic_raster_timer.sv ====
// ========================================
// Raster timer with the beam position counters
// Produces hsync, vsync and a pulse at the start of each visible line,
// all decoded from the same counters so they line up with hcount
// ========================================
`timescale 1ns/1ps

module vic_raster_timer (
  input  logic       clk,
  input  logic       rst,
  output logic [5:0] hcount,
  output logic [4:0] vcount,
  output logic       hsync,
  output logic       vsync,
  output logic       line_start
);
  import vic_video_pkg::*;

  logic h_last;
  logic v_last;

  // Last clock of a line and last line of a frame
  assign h_last = (hcount == 6'(h_total - 1));
  assign v_last = (vcount == 5'(v_total - 1));

  // ========================================
  // Beam counters
  // ========================================

  // The horizontal counter runs every clock and carries into vcount
  always_ff @(posedge clk) begin
    if (rst) begin
      hcount <= '0;
      vcount <= '0;
    end else if (h_last) begin
      hcount <= '0;
      if (v_last) begin
        vcount <= '0;
      end else begin
        vcount <= vcount + 5'd1;
      end
    end else begin
      hcount <= hcount + 6'd1;
    end
  end

  // ========================================
  // Sync and line decode
  // ========================================

  // hsync covers four clocks in the right blanking interval
  assign hsync = (hcount >= 6'(hsync_start)) &&
                 (hcount < 6'(hsync_start + hsync_len));

  // vsync is a whole line in the bottom blanking interval
  assign vsync = (vcount == 5'(vsync_line));

  // Fetching for a line begins at its first clock, visible lines only
  assign line_start = (hcount == 6'd0) && (vcount < 5'(v_visible));

endmodule

// ==== src/vic_reg_file.sv ====
// ========================================
// Host register file of the video controller
// Stores all 64 bytes written by the host and presents the control,
// memory pointer and border fields as decoded structs
// ========================================
`timescale 1ns/1ps

module vic_reg_file (
  input  logic                   clk,
  input  logic                   rst,
  input  vic_regs_pkg::host_wr_t host,
  output vic_regs_pkg::ctrl_t    ctrl,
  output vic_regs_pkg::mem_ptr_t mem_ptr,
  output logic [3:0]             border
);
  import vic_regs_pkg::*;

  // Raw register contents, one byte per address
  logic [7:0] regs [reg_count];

  // ========================================
  // Host writes
  // ========================================

  // A write lands on the edge where we is high, with no wait state
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= 8'h00;
      end
    end else if (host.we) begin
      regs[host.adr] <= host.dat;
    end
  end

  // ========================================
  // Field decode
  // ========================================

  // Only the bits that the video path uses are pulled out here
  // Every other address, including the sprite enable byte, is just kept
  always_comb begin
    ctrl.den = regs[reg_addr_ctrl][ctrl_den_bit];
    ctrl.bmm = regs[reg_addr_ctrl][ctrl_bmm_bit];
  end

  // Upper nibble selects the matrix, bits 3:1 the character set
  always_comb begin
    mem_ptr.vm_base = regs[reg_addr_mem_ptr][7:4];
    mem_ptr.cb_base = regs[reg_addr_mem_ptr][3:1];
  end

  // The border colour uses the low nibble only
  assign border = regs[reg_addr_border][3:0];

endmodule

// ==== src/vic_regs_pkg.sv ====
// ========================================
// Host-side register map of the video controller
// Holds the addresses of the active registers and the structs that
// the register file decodes them into
// ========================================
package vic_regs_pkg;

  // Size of the host register file, addressed by a 6-bit bus
  localparam int reg_count = 64;

  // Addresses of the registers that have a meaning in this design
  localparam logic [5:0] reg_addr_ctrl    = 6'd17;
  localparam logic [5:0] reg_addr_spr_en  = 6'd21;
  localparam logic [5:0] reg_addr_mem_ptr = 6'd24;
  localparam logic [5:0] reg_addr_border  = 6'd32;

  // Bit positions inside the control register
  localparam int ctrl_den_bit = 4;
  localparam int ctrl_bmm_bit = 5;

  // Decoded control register
  typedef struct packed {
    logic den;  // Display enable
    logic bmm;  // Bitmap mode, text mode when clear
  } ctrl_t;

  // Decoded memory pointers
  typedef struct packed {
    // Video matrix base in 1 KiB steps
    logic [3:0] vm_base;
    // Character base in 2 KiB steps
    logic [2:0] cb_base;
  } mem_ptr_t;

  // One write cycle on the host bus
  typedef struct packed {
    logic       we;
    logic [5:0] adr;
    logic [7:0] dat;
  } host_wr_t;

endpackage

// ==== src/vic_top.sv ====
// ========================================
// Top level of the raster video controller
// Joins the register file, raster timer, fetch stage and pixel stage;
// the host bus and the video memory port are the only external links
// ========================================
`timescale 1ns/1ps

module vic_top (
  input  logic                   clk,
  input  logic                   rst,
  input  vic_regs_pkg::host_wr_t host,
  output logic [13:0]            mem_adr,
  output logic                   mem_rd,
  input  logic [11:0]            mem_dat,
  output logic                   hsync,
  output logic                   vsync,
  output vic_video_pkg::pixel_t  pix
);
  import vic_regs_pkg::*;
  import vic_video_pkg::*;

  // Decoded register fields
  ctrl_t       ctrl;
  mem_ptr_t    mem_ptr;
  logic [3:0]  border;

  // Beam position and line start from the timer
  logic [5:0]  hcount;
  logic [4:0]  vcount;
  logic        line_start;

  // Credit-controlled link between fetch and pixel stage
  fetch_item_t item;
  logic        item_valid;
  logic        credit;

  vic_reg_file u_reg_file (
    .clk     (clk),
    .rst     (rst),
    .host    (host),
    .ctrl    (ctrl),
    .mem_ptr (mem_ptr),
    .border  (border)
  );

  vic_raster_timer u_raster_timer (
    .clk        (clk),
    .rst        (rst),
    .hcount     (hcount),
    .vcount     (vcount),
    .hsync      (hsync),
    .vsync      (vsync),
    .line_start (line_start)
  );

  vic_fetch_stage u_fetch_stage (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .mem_ptr    (mem_ptr),
    .line_start (line_start),
    .vcount     (vcount),
    .mem_adr    (mem_adr),
    .mem_rd     (mem_rd),
    .mem_dat    (mem_dat),
    .item       (item),
    .item_valid (item_valid),
    .credit     (credit)
  );

  vic_pixel_stage u_pixel_stage (
    .clk        (clk),
    .rst        (rst),
    .item       (item),
    .item_valid (item_valid),
    .credit     (credit),
    .border     (border),
    .ctrl       (ctrl),
    .hcount     (hcount),
    .vcount     (vcount),
    .pix        (pix)
  );

endmodule

// ==== src/vic_video_pkg.sv ====
// ========================================
// Raster timing and the data types of the video path
// Shared by the raster timer, the fetch stage and the pixel stage
// ========================================
package vic_video_pkg;

  // ========================================
  // Screen geometry
  // ========================================

  // Characters per line and character rows per frame
  localparam int cols      = 4;
  localparam int char_rows = 2;

  // Horizontal timing in clocks, one pixel per clock
  localparam int h_total     = 48;
  localparam int h_visible   = cols * 8;
  localparam int hsync_start = 36;
  localparam int hsync_len   = 4;

  // Vertical timing in lines
  localparam int v_total    = 20;
  localparam int v_visible  = char_rows * 8;
  localparam int vsync_line = 18;

  // Item buffer depth in the pixel stage, equal to the credit count
  localparam int fifo_depth = 4;

  // Derived counter widths
  localparam int col_w    = $clog2(cols);
  localparam int ptr_w    = $clog2(fifo_depth);
  localparam int credit_w = $clog2(fifo_depth + 1);

  // ========================================
  // Data types
  // ========================================

  // Matrix word seen as a character code with its foreground colour
  typedef struct packed {
    logic [3:0] colour;
    logic [7:0] char_code;
  } text_view_t;

  // Matrix word seen as eight bitmap pixels with their colour
  typedef struct packed {
    logic [3:0] colour;
    logic [7:0] bits;
  } bitmap_view_t;

  // The same 12-bit memory word, decoded by display mode
  typedef union packed {
    text_view_t   text;
    bitmap_view_t bitmap;
  } matrix_word_u;

  // One character cell worth of pixels, sent from fetch to pixel stage
  typedef struct packed {
    logic [7:0] bits;
    logic [3:0] colour;
    logic [5:0] x;
    logic [4:0] y;
  } fetch_item_t;

  // One output pixel with its screen position
  typedef struct packed {
    logic       valid;
    logic [5:0] x;
    logic [4:0] y;
    logic [3:0] colour;
  } pixel_t;

endpackage

// ==== tests/vic_props.sv ====
// ========================================
// Concurrent checks on the fetch stage
// Bound into every vic_fetch_stage instance; watches the credit count
// and the memory port while the stage waits for a credit
// ========================================
`timescale 1ns/1ps

module vic_props (
  input logic                               clk,
  input logic                               rst,
  input logic [vic_video_pkg::credit_w-1:0] credits,
  input logic                               wait_credit,
  input logic [13:0]                        mem_adr
);
  import vic_video_pkg::*;

  // The fetch stage can never hold more credits than buffer slots
  credit_max: assert property (@(posedge clk) disable iff (rst)
    credits <= credit_w'(fifo_depth))
    else $error("credit count exceeds the buffer depth");

  // From zero the count may only stay or rise by one, never wrap
  credit_min: assert property (@(posedge clk) disable iff (rst)
    (credits == '0) |=> (credits <= credit_w'(1)))
    else $error("credit count went below zero");

  // A stalled fetch keeps its address for the following clock
  adr_hold: assert property (@(posedge clk) disable iff (rst)
    wait_credit |=> $stable(mem_adr))
    else $error("memory address moved while waiting for a credit");

endmodule

// Attach the checks to the fetch stage internals
bind vic_fetch_stage vic_props u_props (
  .clk         (clk),
  .rst         (rst),
  .credits     (credits),
  .wait_credit (wait_credit),
  .mem_adr     (mem_adr)
);

// ==== tests/vic_tb.sv ====
// ========================================
// Testbench for the raster video controller
// Drives host writes on the falling edge, models the video memory,
// and checks every output pixel against a reference model
// ========================================
`timescale 1ns/1ps

module vic_tb;
  import vic_regs_pkg::*;
  import vic_video_pkg::*;

  // Frame length in clocks and the run limit, 11 frames are used
  localparam int frame_clocks   = h_total * v_total;
  localparam int timeout_cycles = 12 * frame_clocks + 100;
  localparam int sync_window    = 2 * frame_clocks;
  // Display mode per test step: off, text, bitmap, text, bitmap
  localparam logic [7:0] mode_seq [5] = '{8'h00, 8'h10, 8'h30, 8'h10, 8'h30};

  logic        clk = 1'b0;
  logic        rst;
  host_wr_t    host;
  logic [13:0] mem_adr;
  logic        mem_rd;
  logic [11:0] mem_dat = 12'h000;
  logic        hsync;
  logic        vsync;
  pixel_t      pix;

  // Memory model state, a read is answered one clock later
  logic        rd_pending = 1'b0;
  logic [13:0] rd_adr = 14'h0000;

  // Register values as written by the testbench
  logic [7:0]  shadow_ctrl = 8'h00;
  logic [7:0]  shadow_ptr = 8'h00;
  logic [7:0]  shadow_border = 8'h00;

  // Monitor state
  logic [31:0] line_mask [v_visible];
  logic        vsync_q = 1'b0;
  int          sync_samples = 0;
  int          hsync_clocks = 0;
  int          vsync_clocks = 0;
  int          cycle_count = 0;
  int          error_count = 0;

  vic_top uut (
    .clk     (clk),
    .rst     (rst),
    .host    (host),
    .mem_adr (mem_adr),
    .mem_rd  (mem_rd),
    .mem_dat (mem_dat),
    .hsync   (hsync),
    .vsync   (vsync),
    .pix     (pix)
  );

  always #4 clk = ~clk;

  // ========================================
  // Reference model
  // ========================================

  // Memory content is a fixed function of the address
  function automatic logic [11:0] mem_word(input logic [13:0] adr);
    logic [3:0] hi;
    logic [7:0] lo;
    hi = adr[3:0] | 4'h1;
    lo = adr[7:0] ^ adr[13:6];
    return {hi, lo};
  endfunction

  // Colour of the pixel at x, y for the given register bytes
  function automatic logic [3:0] expected_colour(input int x, input int y,
      input logic [7:0] ctrl_r, input logic [7:0] ptr_r, input logic [7:0] border_r);
    int          adr;
    logic [11:0] mat;
    logic [7:0]  bits;
    // Display off shows border everywhere
    if (!ctrl_r[4]) begin
      return border_r[3:0];
    end
    adr = int'(ptr_r[7:4]) * 1024 + (y / 8) * cols + x / 8;
    mat = mem_word(14'(adr));
    if (ctrl_r[5]) begin
      bits = mat[7:0];
    end else begin
      // Text mode reads the glyph line of the character code
      adr = int'(ptr_r[3:1]) * 2048 + int'(mat[7:0]) * 8 + y % 8;
      bits = mem_word(14'(adr)) & 8'hff;
    end
    return bits[7 - (x % 8)] ? mat[11:8] : 4'h0;
  endfunction

  // ========================================
  // Error reporting
  // ========================================

  task automatic stop_with_failure();
    $display("Test failures found");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_failure(input string why);
    error_count++;
    $display("error at %0t ns: %s", $time, why);
    stop_with_failure();
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
      input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  // ========================================
  // Memory model and run limit
  // ========================================

  // Address is captured on one falling edge and answered on the next
  always @(negedge clk) begin
    mem_dat    <= rd_pending ? mem_word(rd_adr) : 12'h000;
    rd_pending <= mem_rd;
    rd_adr     <= mem_adr;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      report_failure("the run did not finish within the cycle limit");
    end
  end

  // ========================================
  // Comparing process
  // ========================================

  always @(negedge clk) begin
    if (!rst) begin
      // Sync duty over exactly two frames
      if (sync_samples < sync_window) begin
        sync_samples++;
        if (hsync) hsync_clocks++;
        if (vsync) vsync_clocks++;
        if (sync_samples == sync_window) begin
          check_equal("hsync clocks", hsync_clocks, 2 * v_total * hsync_len);
          check_equal("vsync clocks", vsync_clocks, 2 * h_total);
        end
      end
      // Fetch must stay quiet while the display is off
      if (!shadow_ctrl[4]) begin
        check_equal("mem_rd", mem_rd, 1'b0);
      end
      if (pix.valid) begin
        if (pix.x >= h_visible || pix.y >= v_visible) begin
          report_failure($sformatf("pixel outside the screen at x %0d y %0d", pix.x, pix.y));
        end
        if (line_mask[pix.y][pix.x]) begin
          report_failure($sformatf("pixel x %0d on line %0d came twice", pix.x, pix.y));
        end
        line_mask[pix.y][pix.x] = 1'b1;
        check_equal($sformatf("pix.colour at x %0d y %0d", pix.x, pix.y), pix.colour,
          expected_colour(pix.x, pix.y, shadow_ctrl, shadow_ptr, shadow_border));
      end
      // Each frame must cover every visible x of every line once
      if (vsync && !vsync_q) begin
        for (int y = 0; y < v_visible; y++) begin
          check_equal($sformatf("line %0d pixel mask", y), line_mask[y], 32'hffff_ffff);
          line_mask[y] = '0;
        end
      end
      vsync_q = vsync;
    end
  end

  // ========================================
  // Stimulus
  // ========================================

  // One host write, driven on the falling edge and held for a clock
  task automatic write_reg(input logic [5:0] adr, input logic [7:0] dat);
    @(negedge clk);
    host.we  = 1'b1;
    host.adr = adr;
    host.dat = dat;
    case (adr)
      reg_addr_ctrl:    shadow_ctrl = dat;
      reg_addr_mem_ptr: shadow_ptr = dat;
      reg_addr_border:  shadow_border = dat;
      default:          ;
    endcase
    @(negedge clk);
    host.we = 1'b0;
  endtask

  // Returns on the first clock of the next vsync line
  task automatic wait_vsync();
    while (vsync) begin
      @(negedge clk);
    end
    while (!vsync) begin
      @(negedge clk);
    end
  endtask

  initial begin
    logic [7:0] ctrl_v;
    rst  = 1'b1;
    host = '0;
    for (int y = 0; y < v_visible; y++) begin
      line_mask[y] = '0;
    end
    void'($urandom(8));
    repeat (8) @(negedge clk);
    rst = 1'b0;
    // Frame 0 runs with all registers cleared
    wait_vsync();
    for (int i = 0; i < 5; i++) begin
      // New pointers and colours land in vertical blanking
      ctrl_v = (8'($urandom) & 8'hcf) | mode_seq[i];
      write_reg(reg_addr_border, 8'($urandom));
      write_reg(reg_addr_mem_ptr, 8'($urandom));
      write_reg(reg_addr_spr_en, 8'($urandom));
      write_reg(reg_addr_ctrl, ctrl_v);
      repeat (2) wait_vsync();
    end
    // Let the last frame check finish
    repeat (2) @(negedge clk);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
